//--- bench/core_tb.sv
/*
 * Testbench for the RV32I multicycle core
 * Runs a hand-checked program under ready stalls, then an illegal opcode
 */
`include "core_settings.svh"

module core_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import core_pkg::*;

    localparam logic [3:0] MAX_STALL = 4'd3;
    localparam int PROG_LEN = 66;
    localparam int CYCLE_LIMIT = 2 * (PROG_LEN * 3 * (MAX_STALL + 1) + PROG_LEN) + 200;
    localparam int EXP_STORES = 17;

    // Store log of the main program as {address, data}
    localparam logic [63:0] EXP_LOG [EXP_STORES] = '{
        {32'h200, 32'd18},          // add
        {32'h204, 32'd32},          // sub
        {32'h208, 32'h190},         // slli
        {32'h20c, 32'hffff_fffc},   // srai
        {32'h210, 32'h0000_000f},   // srli
        {32'h214, 32'd1},
        {32'h218, 32'd0},           // sltu sees -7 as large
        {32'h21c, 32'hffff_ffe0},
        {32'h220, 32'h719},
        {32'h224, 32'h1234_5000},   // lui
        {32'h228, 32'h105c},        // auipc at 0x5c
        {32'h22c, 32'd0},           // Taken branches skip every marker
        {32'h230, 32'h3f},
        {32'h234, 32'hdc},          // jal link
        {32'h238, 32'he4},          // jalr link
        {32'h23c, 32'd0},
        {32'h240, 32'd132}          // Load round trip plus 100
    };

    // Branch funct3 with operand registers {rs1, rs2}
    localparam logic [2:0] BR_F3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    localparam logic [9:0] TAKEN_OPS [6] = '{
        {5'd1, 5'd1}, {5'd1, 5'd2}, {5'd2, 5'd1}, {5'd1, 5'd2}, {5'd1, 5'd2}, {5'd2, 5'd1}
    };
    localparam logic [9:0] NOT_TAKEN_OPS [6] = '{
        {5'd1, 5'd2}, {5'd1, 5'd1}, {5'd1, 5'd2}, {5'd2, 5'd1}, {5'd2, 5'd1}, {5'd1, 5'd2}
    };

    logic               clock;
    logic               reset;
    logic               mem_ready;
    logic [`XLEN-1:0]   mem_rdata;
    logic               mem_valid;
    logic               mem_write;
    logic [`XLEN-1:0]   mem_addr;
    logic [`XLEN-1:0]   mem_wdata;
    logic [`XLEN/8-1:0] mem_byte_en;
    logic               halted;
    logic               illegal_instruction;
    logic               ecall;
    logic               clear;
    logic               load_en;
    logic [7:0]         load_index;
    logic [`XLEN-1:0]   load_data;
    logic [31:0]        program_words [$];
    int                 cycle_count;
    int                 stores_before;

    core_top dut (
        .clock(clock), .reset(reset), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
        .mem_valid(mem_valid), .mem_write(mem_write), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_byte_en(mem_byte_en), .halted(halted),
        .illegal_instruction(illegal_instruction), .ecall(ecall)
    );

    mem_model mem (
        .clock(clock), .max_stall(MAX_STALL), .clear(clear), .load_en(load_en),
        .load_index(load_index), .load_data(load_data), .mem_valid(mem_valid),
        .mem_write(mem_write), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata)
    );

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] op, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic emit(input logic [31:0] word);
        program_words.push_back(word);
    endtask

    task automatic build_main_program;
        program_words.delete();
        emit(i_type(OPC_OP_IMM, 3'd0, 5'd10, 5'd0, 12'h200));  // Store base
        emit(i_type(OPC_OP_IMM, 3'd0, 5'd1, 5'd0, 12'd25));
        emit(i_type(OPC_OP_IMM, 3'd0, 5'd2, 5'd0, 12'hff9));   // -7
        emit(r_type(7'h00, 3'd0, 5'd3, 5'd1, 5'd2));
        emit(s_type(5'd3, 5'd10, 12'd0));
        emit(r_type(7'h20, 3'd0, 5'd4, 5'd1, 5'd2));
        emit(s_type(5'd4, 5'd10, 12'd4));
        emit(i_type(OPC_OP_IMM, 3'd1, 5'd5, 5'd1, 12'd4));
        emit(s_type(5'd5, 5'd10, 12'd8));
        emit(i_type(OPC_OP_IMM, 3'd5, 5'd6, 5'd2, 12'h401));
        emit(s_type(5'd6, 5'd10, 12'd12));
        emit(i_type(OPC_OP_IMM, 3'd5, 5'd7, 5'd2, 12'd28));
        emit(s_type(5'd7, 5'd10, 12'd16));
        emit(r_type(7'h00, 3'd2, 5'd8, 5'd2, 5'd1));
        emit(s_type(5'd8, 5'd10, 12'd20));
        emit(r_type(7'h00, 3'd3, 5'd9, 5'd2, 5'd1));
        emit(s_type(5'd9, 5'd10, 12'd24));
        emit(r_type(7'h00, 3'd4, 5'd11, 5'd1, 5'd2));
        emit(s_type(5'd11, 5'd10, 12'd28));
        emit(i_type(OPC_OP_IMM, 3'd6, 5'd12, 5'd1, 12'h700));
        emit(s_type(5'd12, 5'd10, 12'd32));
        emit(u_type(OPC_LUI, 5'd13, 20'h12345));
        emit(s_type(5'd13, 5'd10, 12'd36));
        emit(u_type(OPC_AUIPC, 5'd14, 20'h00001));
        emit(s_type(5'd14, 5'd10, 12'd40));
        emit(i_type(OPC_OP_IMM, 3'd0, 5'd20, 5'd0, 12'd0));
        emit(i_type(OPC_OP_IMM, 3'd0, 5'd21, 5'd0, 12'd0));
        emit(i_type(OPC_OP_IMM, 3'd0, 5'd23, 5'd0, 12'd0));
        // Each branch skips one ori marker when taken
        for (int k = 0; k < 6; k++) begin
            emit(b_type(BR_F3[k], TAKEN_OPS[k][9:5], TAKEN_OPS[k][4:0], 13'd8));
            emit(i_type(OPC_OP_IMM, 3'd6, 5'd20, 5'd20, 12'd1 << k));
            emit(b_type(BR_F3[k], NOT_TAKEN_OPS[k][9:5], NOT_TAKEN_OPS[k][4:0], 13'd8));
            emit(i_type(OPC_OP_IMM, 3'd6, 5'd21, 5'd21, 12'd1 << k));
        end
        emit(s_type(5'd20, 5'd10, 12'd44));
        emit(s_type(5'd21, 5'd10, 12'd48));
        emit(j_type(5'd22, 21'd8));
        emit(i_type(OPC_OP_IMM, 3'd0, 5'd23, 5'd23, 12'd1));
        emit(i_type(OPC_JALR, 3'd0, 5'd24, 5'd22, 12'd13));     // Odd target loses bit 0
        emit(i_type(OPC_OP_IMM, 3'd0, 5'd23, 5'd23, 12'd1));
        emit(s_type(5'd22, 5'd10, 12'd52));
        emit(s_type(5'd24, 5'd10, 12'd56));
        emit(s_type(5'd23, 5'd10, 12'd60));
        emit(i_type(OPC_LOAD, 3'd2, 5'd25, 5'd10, 12'd4));
        emit(i_type(OPC_OP_IMM, 3'd0, 5'd25, 5'd25, 12'd100));
        emit(s_type(5'd25, 5'd10, 12'd64));
        emit(32'h0000_0073);                                      // ecall
        emit(s_type(5'd1, 5'd10, 12'd68));                       // Never reached
    endtask

    task automatic build_illegal_program;
        program_words.delete();
        emit(i_type(OPC_OP_IMM, 3'd0, 5'd1, 5'd0, 12'd5));
        emit(32'h0000_007f);
        emit(s_type(5'd1, 5'd0, 12'h200));
    endtask

    task automatic next_cycle;
        @(posedge clock);
        #10;
    endtask

    task automatic load_program;
        clear = 1'b1;
        next_cycle();
        clear = 1'b0;
        foreach (program_words[i]) begin
            load_en = 1'b1;
            load_index = 8'(i);
            load_data = program_words[i];
            next_cycle();
        end
        load_en = 1'b0;
    endtask

    task automatic pulse_reset;
        reset = 1'b1;
        repeat (8) next_cycle();
        reset = 1'b0;
    endtask

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("tests failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic wait_for_halt;
        while (!halted) @(negedge clock);
    endtask

    task automatic check_halt_flags(input logic exp_ecall, input logic exp_illegal);
        assert (halted && ecall == exp_ecall && illegal_instruction == exp_illegal)
        else abort_run($sformatf("FAILED at %0t: halted=%b ecall=%b illegal=%b, expected 1 %b %b",
                                 $time, halted, ecall, illegal_instruction,
                                 exp_ecall, exp_illegal));
    endtask

    task automatic check_store_log;
        assert (mem.log_count == EXP_STORES)
        else abort_run($sformatf("FAILED at %0t: %0d stores logged, expected %0d",
                                 $time, mem.log_count, EXP_STORES));
        for (int i = 0; i < EXP_STORES; i++) begin
            assert (mem.log_addr[i] == EXP_LOG[i][63:32] && mem.log_data[i] == EXP_LOG[i][31:0])
            else abort_run($sformatf("FAILED at %0t: store %0d wrote %h to %h, expected %h to %h",
                                     $time, i, mem.log_data[i], mem.log_addr[i],
                                     EXP_LOG[i][31:0], EXP_LOG[i][63:32]));
        end
    endtask

    task automatic check_bus_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            assert (!mem_valid && halted)
            else abort_run($sformatf("FAILED at %0t: memory request after halt", $time));
        end
    endtask

    // Every access is a full word
    always @(negedge clock) begin
        if (mem_valid) begin
            assert (mem_byte_en == '1)
            else abort_run($sformatf("FAILED at %0t: byte enable %b on a word access",
                                     $time, mem_byte_en));
        end
    end

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clock);
            cycle_count++;
            if (cycle_count > CYCLE_LIMIT) begin
                abort_run($sformatf("Timeout: the core did not halt within %0d cycles",
                                    CYCLE_LIMIT));
            end
        end
    end

    initial begin
        reset = 1'b1;
        clear = 1'b0;
        load_en = 1'b0;
        load_index = 8'd0;
        load_data = '0;

        build_main_program();
        load_program();
        pulse_reset();
        wait_for_halt();
        check_halt_flags(1'b1, 1'b0);
        check_store_log();
        check_bus_idle(20);

        // Second run ends on an unknown opcode
        stores_before = mem.log_count;
        build_illegal_program();
        load_program();
        pulse_reset();
        wait_for_halt();
        check_halt_flags(1'b0, 1'b1);
        check_bus_idle(20);
        assert (mem.log_count == stores_before)
        else abort_run($sformatf("FAILED at %0t: store after illegal instruction", $time));

        $display("all tests passed");
        $finish;
    end

endmodule

//--- bench/mem_model.sv
/*
 * Test memory for the core
 * Word array with a load port, LCG-driven ready stalls and a store log
 */
`include "core_settings.svh"

module mem_model (
    input  logic             clock,
    input  logic [3:0]       max_stall,
    input  logic             clear,
    input  logic             load_en,
    input  logic [7:0]       load_index,
    input  logic [`XLEN-1:0] load_data,
    input  logic             mem_valid,
    input  logic             mem_write,
    input  logic [`XLEN-1:0] mem_addr,
    input  logic [`XLEN-1:0] mem_wdata,
    output logic             mem_ready,
    output logic [`XLEN-1:0] mem_rdata
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [`XLEN-1:0] words [256];
    logic [`XLEN-1:0] log_addr [64];
    logic [`XLEN-1:0] log_data [64];
    int               log_count = 0;
    logic [31:0]      seed;
    logic [3:0]       stall_run;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    assign mem_rdata = words[mem_addr[9:2]];  // Valid in the transfer cycle

    // Ready low never lasts longer than max_stall cycles
    initial begin
        seed = 32'hc0c7;
        stall_run = 4'd0;
        mem_ready = 1'b0;
        forever begin
            @(posedge clock);
            #5;
            seed = lcg_next(seed);
            if (seed[16] && stall_run < max_stall) begin
                mem_ready = 1'b0;
                stall_run = stall_run + 4'd1;
            end else begin
                mem_ready = 1'b1;
                stall_run = 4'd0;
            end
        end
    end

    always @(posedge clock) begin
        if (clear) begin
            for (int i = 0; i < 256; i++) words[i] <= 32'hdead_0000 ^ (32'(i) << 2);
        end else if (load_en) begin
            words[load_index] <= load_data;
        end else if (mem_valid && mem_ready && mem_write) begin
            words[mem_addr[9:2]] <= mem_wdata;
            if (log_count < 64) begin
                log_addr[log_count] <= mem_addr;
                log_data[log_count] <= mem_wdata;
            end
            log_count <= log_count + 1;
        end
    end

endmodule

//--- design/control_unit.sv
/*
 * Control unit
 * Multicycle FSM: fetch, decode with legality check, one execute state
 * per instruction class. Halts for good on ECALL or an illegal instruction
 */
module control_unit (
    input  logic    clock,
    input  logic    reset,
    input  logic    mem_ack,
    output logic    rd_en,
    output logic    wr_en,
    output logic    halted,
    output logic    illegal_instruction,
    output logic    ecall,
    core_ctrl_if.ctrl bus
);
    import core_pkg::*;

    state_e state;
    state_e next_state;
    logic   dec_illegal;
    logic   dec_ecall;
    logic   beq_bne;
    logic   blt_bge;
    logic   bltu_bgeu;
    logic   branch_taken;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Sticky until reset
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            illegal_instruction <= 1'b0;
            ecall <= 1'b0;
        end else if (state == ST_DECODE) begin
            if (dec_illegal) illegal_instruction <= 1'b1;
            if (dec_ecall) ecall <= 1'b1;
        end
    end

    assign halted = (state == ST_HALT);

    // Flags come from rs1 - rs2
    assign beq_bne = bus.flags.zero ^ bus.funct3[0];
    assign blt_bge = (bus.flags.negative ^ bus.flags.overflow) ^ bus.funct3[0];
    assign bltu_bgeu = bus.flags.carry_out ~^ bus.funct3[0];
    assign branch_taken = bus.funct3[2] ? (bus.funct3[1] ? bltu_bgeu : blt_bge) : beq_bne;

    always_comb begin
        rd_en = 1'b0;
        wr_en = 1'b0;
        bus.alua_src = 1'b0;
        bus.alub_src = 1'b0;
        bus.alu_op = ALU_ADD;
        bus.sub = 1'b0;
        bus.arithmetic = 1'b0;
        bus.alupc_src = 1'b0;
        bus.pc_src = 1'b0;
        bus.pc_en = 1'b0;
        bus.wb_src = WB_ALU;
        bus.wr_reg_en = 1'b0;
        bus.ir_en = 1'b0;
        bus.mem_addr_src = 1'b0;
        dec_illegal = 1'b0;
        dec_ecall = 1'b0;
        next_state = ST_FETCH;

        case (state)
            ST_IDLE: next_state = ST_FETCH;

            ST_FETCH: begin
                rd_en = 1'b1;
                if (mem_ack) begin
                    bus.ir_en = 1'b1;
                    next_state = ST_DECODE;
                end else begin
                    next_state = ST_FETCH;
                end
            end

            ST_DECODE: begin
                case (bus.opcode)
                    OPC_OP: begin
                        next_state = ST_REG_REG;
                        if (bus.funct3 == 3'b000 || bus.funct3 == 3'b101) begin
                            dec_illegal = ({bus.funct7[6], bus.funct7[4:0]} != 6'd0);
                        end else begin
                            dec_illegal = (bus.funct7 != 7'd0);
                        end
                    end
                    OPC_OP_IMM: begin
                        next_state = ST_REG_IMM;
                        if (bus.funct3 == 3'b001) dec_illegal = (bus.funct7 != 7'd0);
                        if (bus.funct3 == 3'b101)
                            dec_illegal = ({bus.funct7[6], bus.funct7[4:0]} != 6'd0);
                    end
                    OPC_LOAD: begin
                        next_state = ST_LOAD;
                        dec_illegal = (bus.funct3 != 3'b010);  // Words only
                    end
                    OPC_STORE: begin
                        next_state = ST_STORE;
                        dec_illegal = (bus.funct3 != 3'b010);
                    end
                    OPC_BRANCH: begin
                        next_state = ST_BRANCH;
                        dec_illegal = (bus.funct3[2:1] == 2'b01);
                    end
                    OPC_LUI:   next_state = ST_LUI;
                    OPC_AUIPC: next_state = ST_AUIPC;
                    OPC_JAL:   next_state = ST_JAL;
                    OPC_JALR: begin
                        next_state = ST_JALR;
                        dec_illegal = (bus.funct3 != 3'b000);
                    end
                    OPC_SYSTEM: begin
                        if (bus.funct3 == 3'b000 && bus.funct7 == 7'd0) dec_ecall = 1'b1;
                        else dec_illegal = 1'b1;
                    end
                    default: dec_illegal = 1'b1;
                endcase
                if (dec_illegal || dec_ecall) next_state = ST_HALT;
            end

            ST_REG_REG: begin
                bus.alu_op = alu_op_e'(bus.funct3);
                bus.sub = bus.funct7[5];
                bus.arithmetic = bus.funct7[5];
                bus.pc_en = 1'b1;
                bus.wr_reg_en = 1'b1;
            end

            ST_REG_IMM: begin
                bus.alub_src = 1'b1;
                bus.alu_op = alu_op_e'(bus.funct3);
                bus.arithmetic = bus.funct7[5] & (bus.funct3 == 3'b101);  // SRAI only
                bus.pc_en = 1'b1;
                bus.wr_reg_en = 1'b1;
            end

            ST_LUI: begin
                bus.alub_src = 1'b1;  // Datapath zeroes operand A
                bus.pc_en = 1'b1;
                bus.wr_reg_en = 1'b1;
            end

            ST_AUIPC: begin
                bus.alua_src = 1'b1;
                bus.alub_src = 1'b1;
                bus.pc_en = 1'b1;
                bus.wr_reg_en = 1'b1;
            end

            ST_JAL: begin
                bus.pc_src = 1'b1;
                bus.pc_en = 1'b1;
                bus.wb_src = WB_PC4;
                bus.wr_reg_en = 1'b1;
            end

            ST_BRANCH: begin
                bus.sub = 1'b1;
                bus.pc_src = branch_taken;
                bus.pc_en = 1'b1;
            end

            ST_JALR: begin
                bus.alub_src = 1'b1;  // rs1 + imm
                bus.alupc_src = 1'b1;
                bus.pc_src = 1'b1;
                bus.pc_en = 1'b1;
                bus.wb_src = WB_PC4;
                bus.wr_reg_en = 1'b1;
            end

            ST_LOAD: begin
                rd_en = 1'b1;
                bus.mem_addr_src = 1'b1;
                bus.alub_src = 1'b1;
                bus.wb_src = WB_MEM;
                if (mem_ack) begin
                    bus.pc_en = 1'b1;
                    bus.wr_reg_en = 1'b1;
                end else begin
                    next_state = ST_LOAD;
                end
            end

            ST_STORE: begin
                wr_en = 1'b1;
                bus.mem_addr_src = 1'b1;
                bus.alub_src = 1'b1;
                if (mem_ack) bus.pc_en = 1'b1;
                else next_state = ST_STORE;
            end

            ST_HALT: next_state = ST_HALT;

            default: next_state = ST_IDLE;
        endcase
    end

endmodule

//--- design/core_ctrl_if.sv
/*
 * Control bus between control unit and datapath
 * Steering signals one way, instruction fields and ALU flags back
 */
interface core_ctrl_if;
    import core_pkg::*;

    logic       alua_src;      // PC as operand A
    logic       alub_src;      // Immediate as operand B
    alu_op_e    alu_op;
    logic       sub;
    logic       arithmetic;
    logic       alupc_src;     // JALR target
    logic       pc_src;
    logic       pc_en;
    wb_src_e    wb_src;
    logic       wr_reg_en;
    logic       ir_en;
    logic       mem_addr_src;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_flags_t flags;

    modport ctrl (
        output alua_src, alub_src, alu_op, sub, arithmetic, alupc_src,
        output pc_src, pc_en, wb_src, wr_reg_en, ir_en, mem_addr_src,
        input  opcode, funct3, funct7, flags
    );

    modport dp (
        input  alua_src, alub_src, alu_op, sub, arithmetic, alupc_src,
        input  pc_src, pc_en, wb_src, wr_reg_en, ir_en, mem_addr_src,
        output opcode, funct3, funct7, flags
    );

endinterface

//--- design/core_pkg.sv
/*
 * Core package
 * Opcode, FSM state, write-back, ALU function and flag types
 */
package core_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ST_IDLE, ST_FETCH, ST_DECODE, ST_REG_REG, ST_REG_IMM, ST_LUI, ST_AUIPC,
        ST_JAL, ST_BRANCH, ST_JALR, ST_LOAD, ST_STORE, ST_HALT
    } state_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_src_e;

    // Same order as funct3
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SR, ALU_OR, ALU_AND
    } alu_op_e;

    typedef struct packed {
        logic zero;
        logic negative;
        logic carry_out;
        logic overflow;
    } alu_flags_t;

endpackage

//--- design/core_settings.svh
/*
 * Core settings
 * Data width, reset PC and register count of the RV32I core
 */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define XLEN 32

// First fetch address
`define RESET_PC 32'h0

`define REG_COUNT 32

`endif

//--- design/core_top.sv
/*
 * RV32I multicycle core top
 * Control unit, datapath and memory port behind one valid/ready bus
 */
`include "core_settings.svh"

module core_top (
    input  logic               clock,
    input  logic               reset,
    input  logic               mem_ready,
    input  logic [`XLEN-1:0]   mem_rdata,
    output logic               mem_valid,
    output logic               mem_write,
    output logic [`XLEN-1:0]   mem_addr,
    output logic [`XLEN-1:0]   mem_wdata,
    output logic [`XLEN/8-1:0] mem_byte_en,
    output logic               halted,
    output logic               illegal_instruction,
    output logic               ecall
);

    core_ctrl_if ctrl_bus ();

    logic             rd_en;
    logic             wr_en;
    logic             mem_ack;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] store_data;
    logic [`XLEN-1:0] rdata;

    control_unit u_control_unit (
        .clock(clock), .reset(reset), .mem_ack(mem_ack),
        .rd_en(rd_en), .wr_en(wr_en), .halted(halted),
        .illegal_instruction(illegal_instruction), .ecall(ecall), .bus(ctrl_bus)
    );

    datapath u_datapath (
        .clock(clock), .reset(reset), .mem_rdata(rdata), .pc(pc),
        .alu_result(alu_result), .store_data(store_data), .bus(ctrl_bus)
    );

    mem_port u_mem_port (
        .rd_en(rd_en), .wr_en(wr_en), .mem_addr_src(ctrl_bus.mem_addr_src),
        .pc(pc), .alu_result(alu_result), .store_data(store_data),
        .mem_ready(mem_ready), .bus_rdata(mem_rdata), .mem_ack(mem_ack),
        .mem_rdata(rdata), .mem_valid(mem_valid), .mem_write(mem_write),
        .mem_addr(mem_addr), .mem_byte_en(mem_byte_en), .mem_wdata(mem_wdata)
    );

endmodule

//--- design/datapath.sv
/*
 * Datapath
 * PC, instruction register, register file, immediate generation, ALU
 * with flags, write-back and next-PC selection
 */
`include "core_settings.svh"

module datapath (
    input  logic             clock,
    input  logic             reset,
    input  logic [`XLEN-1:0] mem_rdata,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] alu_result,
    output logic [`XLEN-1:0] store_data,
    core_ctrl_if.dp          bus
);
    import core_pkg::*;

    localparam int REG_AW = $clog2(`REG_COUNT);
    localparam int SHAMT_W = $clog2(`XLEN);

    logic [`XLEN-1:0]   ir;
    logic [`XLEN-1:0]   regs [`REG_COUNT];
    logic [REG_AW-1:0]  rs1_addr;
    logic [REG_AW-1:0]  rs2_addr;
    logic [REG_AW-1:0]  rd_addr;
    logic [`XLEN-1:0]   rs1_data;
    logic [`XLEN-1:0]   rs2_data;
    logic [`XLEN-1:0]   imm;
    logic [`XLEN-1:0]   op_a;
    logic [`XLEN-1:0]   op_b;
    logic [`XLEN:0]     diff;
    logic [`XLEN-1:0]   sum;
    logic [SHAMT_W-1:0] shamt;
    logic [`XLEN-1:0]   pc_plus4;
    logic [`XLEN-1:0]   next_pc;
    logic [`XLEN-1:0]   wb_data;
    alu_flags_t         flags;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) pc <= `RESET_PC;
        else if (bus.pc_en) pc <= next_pc;
    end

    always_ff @(posedge clock) begin
        if (bus.ir_en) ir <= mem_rdata;
    end

    assign bus.opcode = ir[6:0];
    assign bus.funct3 = ir[14:12];
    assign bus.funct7 = ir[31:25];

    // LUI reads x0 so the adder passes the immediate
    assign rs1_addr = (bus.opcode == OPC_LUI) ? '0 : ir[15 +: REG_AW];
    assign rs2_addr = ir[20 +: REG_AW];
    assign rd_addr = ir[7 +: REG_AW];

    always_ff @(posedge clock) begin
        if (bus.wr_reg_en && rd_addr != '0) regs[rd_addr] <= wb_data;
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
    assign store_data = rs2_data;

    always_comb begin
        case (bus.opcode)
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: imm = {{(`XLEN-12){ir[31]}}, ir[31:20]};
            OPC_STORE:  imm = {{(`XLEN-12){ir[31]}}, ir[31:25], ir[11:7]};
            OPC_BRANCH: imm = {{(`XLEN-12){ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC: imm = {ir[31:12], 12'd0};
            OPC_JAL: imm = {{(`XLEN-20){ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    assign op_a = bus.alua_src ? pc : rs1_data;
    assign op_b = bus.alub_src ? imm : rs2_data;
    assign shamt = op_b[SHAMT_W-1:0];

    // a + ~b + 1 with carry set when a >= b unsigned
    assign diff = {1'b0, op_a} + {1'b0, ~op_b} + 1'b1;
    assign sum = bus.sub ? diff[`XLEN-1:0] : op_a + op_b;

    assign flags.zero = (diff[`XLEN-1:0] == '0);
    assign flags.negative = diff[`XLEN-1];
    assign flags.carry_out = diff[`XLEN];
    assign flags.overflow = (op_a[`XLEN-1] != op_b[`XLEN-1]) &&
                            (diff[`XLEN-1] != op_a[`XLEN-1]);
    assign bus.flags = flags;

    always_comb begin
        case (bus.alu_op)
            ALU_ADD:  alu_result = sum;
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SLT:  alu_result = {{(`XLEN-1){1'b0}}, flags.negative ^ flags.overflow};
            ALU_SLTU: alu_result = {{(`XLEN-1){1'b0}}, ~flags.carry_out};
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SR: begin
                if (bus.arithmetic) alu_result = $signed(op_a) >>> shamt;
                else alu_result = op_a >> shamt;
            end
            ALU_OR:   alu_result = op_a | op_b;
            default:  alu_result = op_a & op_b;
        endcase
    end

    assign pc_plus4 = pc + `XLEN'd4;

    always_comb begin
        case (bus.wb_src)
            WB_MEM:  wb_data = mem_rdata;
            WB_PC4:  wb_data = pc_plus4;  // Link value
            default: wb_data = alu_result;
        endcase
    end

    always_comb begin
        if (bus.alupc_src) next_pc = {alu_result[`XLEN-1:1], 1'b0};
        else if (bus.pc_src) next_pc = pc + imm;
        else next_pc = pc_plus4;
    end

endmodule

//--- design/mem_port.sv
/*
 * Memory port
 * Merges fetch and data requests onto one valid/ready bus
 */
`include "core_settings.svh"

module mem_port (
    input  logic                 rd_en,
    input  logic                 wr_en,
    input  logic                 mem_addr_src,
    input  logic [`XLEN-1:0]     pc,
    input  logic [`XLEN-1:0]     alu_result,
    input  logic [`XLEN-1:0]     store_data,
    input  logic                 mem_ready,
    input  logic [`XLEN-1:0]     bus_rdata,
    output logic                 mem_ack,
    output logic [`XLEN-1:0]     mem_rdata,
    output logic                 mem_valid,
    output logic                 mem_write,
    output logic [`XLEN-1:0]     mem_addr,
    output logic [`XLEN/8-1:0]   mem_byte_en,
    output logic [`XLEN-1:0]     mem_wdata
);

    assign mem_valid = rd_en | wr_en;
    assign mem_write = wr_en;

    // Instruction fetch uses the PC, loads and stores the ALU sum
    assign mem_addr = mem_addr_src ? alu_result : pc;

    assign mem_wdata = store_data;
    assign mem_byte_en = '1;  // Word accesses only

    // Transfer completes on valid and ready
    assign mem_ack = mem_valid & mem_ready;
    assign mem_rdata = bus_rdata;

endmodule

//--- project.f
+incdir+design
design/core_pkg.sv
design/core_ctrl_if.sv
design/control_unit.sv
design/datapath.sv
design/mem_port.sv
design/core_top.sv
bench/mem_model.sv
bench/core_tb.sv

//--- run.sh
#!/bin/sh
# Builds the core testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    -f project.f \
    --top-module core_tb \
    --Mdir obj_dir \
    -o core_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/core_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
